// ==== Bender.yml ====
package:
  name: soc_membus

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/membus_pkg.sv
      - common/mmio_pkg.sv
      - rtl/timebase.sv
      - rtl/mmio_ctrl.sv
      - membus/mem_bus_arbiter.sv
      - membus/main_memory.sv
      - rtl/soc_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_soc_top.sv

// ==== common/membus_pkg.sv ====
`default_nettype none

package membus_pkg;

    // Byte address as issued by fetch and data masters
    typedef logic [31:0] addr_t;

    // One bus word
    typedef logic [31:0] word_t;

    // Arbiter ownership of the memory port
    typedef enum logic [1:0] {
        IDLE,   // No transaction in flight
        WAIT_I, // Fetch owns the pending response
        WAIT_D  // Data owns the pending response
    } arb_state_e;

endpackage

`default_nettype wire

// ==== common/mmio_pkg.sv ====
`default_nettype none

package mmio_pkg;

    // Timer and counter width
    typedef logic [63:0] timer_t;

    // Word offsets from the MMIO base
    typedef enum logic [29:0] {
        MTIME_LO    = 30'd0,
        MTIME_HI    = 30'd1,
        MTIMECMP_LO = 30'd2,
        MTIMECMP_HI = 30'd3,
        GP          = 30'd4 // Bit 0 set on write requests exit
    } mmio_reg_e;

endpackage

`default_nettype wire

// ==== common/soc_settings.svh ====
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Clock frequency in MHz and the number of cycles per microsecond
`define FMAX_MHZ 27

// Word address bits of the main memory (1024 words)
`define MEM_ADDR_WIDTH 10

// Data requests at or above this byte address go to the MMIO registers
`define MMIO_BASE 32'h4000_0000

`endif

// ==== flist.f ====
+incdir+common
common/membus_pkg.sv
common/mmio_pkg.sv
rtl/timebase.sv
rtl/mmio_ctrl.sv
membus/mem_bus_arbiter.sv
membus/main_memory.sv
rtl/soc_top.sv
tb/tb_soc_top.sv

// ==== membus/main_memory.sv ====
`default_nettype none

`include "soc_settings.svh"

module main_memory (
    input  wire                 clk_in,
    input  wire                 arst_n,
    input  wire                 req_valid,
    output logic                req_ready,
    input  membus_pkg::addr_t   req_addr,
    input  wire                 req_wen,
    input  membus_pkg::word_t   req_wdata,
    output logic                resp_valid,
    output membus_pkg::word_t   resp_rdata
);

    localparam int DEPTH = 2 ** `MEM_ADDR_WIDTH;

    membus_pkg::word_t          mem [DEPTH];
    logic [`MEM_ADDR_WIDTH-1:0] idx;

    assign req_ready = 1'b1;
    assign idx       = req_addr[`MEM_ADDR_WIDTH+1:2]; // Upper bits wrap

    // Power-up contents are zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (req_valid) begin
            if (req_wen) begin
                mem[idx] <= req_wdata;
            end
            resp_rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid && req_ready;
        end
    end

endmodule

`default_nettype wire

// ==== membus/mem_bus_arbiter.sv ====
`default_nettype none

module mem_bus_arbiter (
    input  wire                 clk_in,
    input  wire                 arst_n,

    input  wire                 i_req_valid,
    output logic                i_req_ready,
    input  membus_pkg::addr_t   i_req_addr,
    output logic                i_resp_valid,
    output membus_pkg::word_t   i_resp_rdata,

    input  wire                 d_req_valid,
    output logic                d_req_ready,
    input  membus_pkg::addr_t   d_req_addr,
    input  wire                 d_req_wen,
    input  membus_pkg::word_t   d_req_wdata,
    output logic                d_resp_valid,
    output membus_pkg::word_t   d_resp_rdata,

    output logic                mem_req_valid,
    input  wire                 mem_req_ready,
    output membus_pkg::addr_t   mem_req_addr,
    output logic                mem_req_wen,
    output membus_pkg::word_t   mem_req_wdata,
    input  wire                 mem_resp_valid,
    input  membus_pkg::word_t   mem_resp_rdata
);

    membus_pkg::arb_state_e state;
    logic                   idle;

    assign idle = (state == membus_pkg::IDLE);

    // Data wins when both masters ask in the same cycle
    assign mem_req_valid = idle && (d_req_valid || i_req_valid);
    assign mem_req_addr  = d_req_valid ? d_req_addr : i_req_addr;
    assign mem_req_wen   = d_req_valid && d_req_wen; // Fetch never writes
    assign mem_req_wdata = d_req_wdata;

    assign d_req_ready = idle && mem_req_ready;
    assign i_req_ready = idle && mem_req_ready && !d_req_valid;

    assign i_resp_valid = (state == membus_pkg::WAIT_I) && mem_resp_valid;
    assign d_resp_valid = (state == membus_pkg::WAIT_D) && mem_resp_valid;
    assign i_resp_rdata = mem_resp_rdata;
    assign d_resp_rdata = mem_resp_rdata;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state <= membus_pkg::IDLE;
        end else begin
            case (state)
                membus_pkg::IDLE: begin
                    if (mem_req_valid && mem_req_ready) begin
                        state <= d_req_valid ? membus_pkg::WAIT_D : membus_pkg::WAIT_I;
                    end
                end
                membus_pkg::WAIT_I, membus_pkg::WAIT_D: begin
                    if (mem_resp_valid) begin
                        state <= membus_pkg::IDLE;
                    end
                end
                default: state <= membus_pkg::IDLE;
            endcase
        end
    end

    // Memory only answers requests this arbiter issued
    no_resp_in_idle: assert property (
        @(posedge clk_in) disable iff (!arst_n) !(idle && mem_resp_valid)
    );

    one_owner: assert property (
        @(posedge clk_in) disable iff (!arst_n) !(i_resp_valid && d_resp_valid)
    );

endmodule

`default_nettype wire

// ==== rtl/mmio_ctrl.sv ====
`default_nettype none

`include "soc_settings.svh"

module mmio_ctrl (
    input  wire                 clk_in,
    input  wire                 arst_n,

    input  wire                 d_req_valid,
    output logic                d_req_ready,
    input  membus_pkg::addr_t   d_req_addr,
    input  wire                 d_req_wen,
    input  membus_pkg::word_t   d_req_wdata,
    output logic                d_resp_valid,
    output membus_pkg::word_t   d_resp_rdata,

    output logic                m_req_valid,
    input  wire                 m_req_ready,
    output membus_pkg::addr_t   m_req_addr,
    output logic                m_req_wen,
    output membus_pkg::word_t   m_req_wdata,
    input  wire                 m_resp_valid,
    input  membus_pkg::word_t   m_resp_rdata,

    input  mmio_pkg::timer_t    mtime,
    output logic                timer_irq,
    output membus_pkg::word_t   gp,
    output logic                exit
);

    membus_pkg::addr_t  rel_addr;
    logic               is_mmio;
    logic               mmio_acc;
    logic               mmio_wr;
    logic               mmio_resp_valid;
    membus_pkg::word_t  mmio_rdata;
    membus_pkg::word_t  rd_next;
    mmio_pkg::timer_t   mtimecmp;

    assign is_mmio  = (d_req_addr >= `MMIO_BASE);
    assign rel_addr = d_req_addr - `MMIO_BASE;

    // Memory traffic passes straight through
    assign m_req_valid = d_req_valid && !is_mmio;
    assign m_req_addr  = d_req_addr;
    assign m_req_wen   = d_req_wen;
    assign m_req_wdata = d_req_wdata;

    assign d_req_ready  = is_mmio ? !mmio_resp_valid : m_req_ready;
    assign mmio_acc     = d_req_valid && is_mmio && !mmio_resp_valid;
    assign mmio_wr      = mmio_acc && d_req_wen;

    assign d_resp_valid = mmio_resp_valid || m_resp_valid;
    assign d_resp_rdata = mmio_resp_valid ? mmio_rdata : m_resp_rdata;

    assign timer_irq = (mtime >= mtimecmp);

    always_comb begin
        rd_next = '0; // Unmapped offsets read zero
        case (rel_addr[31:2])
            mmio_pkg::MTIME_LO:    rd_next = mtime[31:0];
            mmio_pkg::MTIME_HI:    rd_next = mtime[63:32];
            mmio_pkg::MTIMECMP_LO: rd_next = mtimecmp[31:0];
            mmio_pkg::MTIMECMP_HI: rd_next = mtimecmp[63:32];
            mmio_pkg::GP:          rd_next = gp;
            default:               rd_next = '0;
        endcase
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            mmio_resp_valid <= 1'b0;
            mtimecmp        <= '1; // Keeps the interrupt quiet until programmed
            gp              <= '0;
            exit            <= 1'b0;
        end else begin
            mmio_resp_valid <= mmio_acc;
            exit            <= mmio_wr && (rel_addr[31:2] == mmio_pkg::GP) && d_req_wdata[0];
            if (mmio_wr) begin
                case (rel_addr[31:2])
                    mmio_pkg::MTIMECMP_LO: mtimecmp[31:0]  <= d_req_wdata;
                    mmio_pkg::MTIMECMP_HI: mtimecmp[63:32] <= d_req_wdata;
                    mmio_pkg::GP:          gp              <= d_req_wdata;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (mmio_acc) begin
            mmio_rdata <= rd_next;
        end
    end

    // Only one kind of response can be outstanding on the data port
    no_resp_overlap: assert property (
        @(posedge clk_in) disable iff (!arst_n) !(mmio_resp_valid && m_resp_valid)
    );

endmodule

`default_nettype wire

// ==== rtl/soc_top.sv ====
`default_nettype none

module soc_top (
    input  wire                 clk_in,
    input  wire                 arst_n,

    input  wire                 i_req_valid,
    output logic                i_req_ready,
    input  membus_pkg::addr_t   i_req_addr,
    output logic                i_resp_valid,
    output membus_pkg::word_t   i_resp_rdata,

    input  wire                 d_req_valid,
    output logic                d_req_ready,
    input  membus_pkg::addr_t   d_req_addr,
    input  wire                 d_req_wen,
    input  membus_pkg::word_t   d_req_wdata,
    output logic                d_resp_valid,
    output membus_pkg::word_t   d_resp_rdata,

    output logic                timer_irq,
    output membus_pkg::word_t   gp,
    output logic                exited
);

    mmio_pkg::timer_t   mtime;
    logic               exit;

    // Data path between MMIO controller and arbiter
    logic               md_req_valid;
    logic               md_req_ready;
    membus_pkg::addr_t  md_req_addr;
    logic               md_req_wen;
    membus_pkg::word_t  md_req_wdata;
    logic               md_resp_valid;
    membus_pkg::word_t  md_resp_rdata;

    // Single memory port
    logic               mem_req_valid;
    logic               mem_req_ready;
    membus_pkg::addr_t  mem_req_addr;
    logic               mem_req_wen;
    membus_pkg::word_t  mem_req_wdata;
    logic               mem_resp_valid;
    membus_pkg::word_t  mem_resp_rdata;

    timebase u_timebase (
        .clk_in (clk_in),
        .arst_n (arst_n),
        .cycle  (),      // Reserved for the core's cycle CSR
        .mtime  (mtime)
    );

    mmio_ctrl u_mmio_ctrl (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .d_req_valid  (d_req_valid),
        .d_req_ready  (d_req_ready),
        .d_req_addr   (d_req_addr),
        .d_req_wen    (d_req_wen),
        .d_req_wdata  (d_req_wdata),
        .d_resp_valid (d_resp_valid),
        .d_resp_rdata (d_resp_rdata),
        .m_req_valid  (md_req_valid),
        .m_req_ready  (md_req_ready),
        .m_req_addr   (md_req_addr),
        .m_req_wen    (md_req_wen),
        .m_req_wdata  (md_req_wdata),
        .m_resp_valid (md_resp_valid),
        .m_resp_rdata (md_resp_rdata),
        .mtime        (mtime),
        .timer_irq    (timer_irq),
        .gp           (gp),
        .exit         (exit)
    );

    mem_bus_arbiter u_arbiter (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .i_req_valid    (i_req_valid),
        .i_req_ready    (i_req_ready),
        .i_req_addr     (i_req_addr),
        .i_resp_valid   (i_resp_valid),
        .i_resp_rdata   (i_resp_rdata),
        .d_req_valid    (md_req_valid),
        .d_req_ready    (md_req_ready),
        .d_req_addr     (md_req_addr),
        .d_req_wen      (md_req_wen),
        .d_req_wdata    (md_req_wdata),
        .d_resp_valid   (md_resp_valid),
        .d_resp_rdata   (md_resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wen    (mem_req_wen),
        .mem_req_wdata  (mem_req_wdata),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata)
    );

    main_memory u_memory (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .req_valid  (mem_req_valid),
        .req_ready  (mem_req_ready),
        .req_addr   (mem_req_addr),
        .req_wen    (mem_req_wen),
        .req_wdata  (mem_req_wdata),
        .resp_valid (mem_resp_valid),
        .resp_rdata (mem_resp_rdata)
    );

    // Sticky until reset
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            exited <= 1'b0;
        end else if (exit) begin
            exited <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/timebase.sv ====
`default_nettype none

`include "soc_settings.svh"

module timebase (
    input  wire               clk_in,
    input  wire               arst_n,
    output mmio_pkg::timer_t  cycle,
    output mmio_pkg::timer_t  mtime
);

    localparam int PRESC_W = (`FMAX_MHZ > 1) ? $clog2(`FMAX_MHZ) : 1;

    logic [PRESC_W-1:0] presc;
    logic               tick_us;

    assign tick_us = (presc == PRESC_W'(`FMAX_MHZ - 1));

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= '0;
            mtime <= '0;
            presc <= '0;
        end else begin
            cycle <= cycle + 64'd1;
            if (tick_us) begin
                presc <= '0;
                mtime <= mtime + 64'd1; // One microsecond elapsed
            end else begin
                presc <= presc + PRESC_W'(1);
            end
        end
    end

    // Time only moves forward
    mtime_monotonic: assert property (
        @(posedge clk_in) disable iff (!arst_n) mtime >= $past(mtime)
    );

endmodule

`default_nettype wire

// ==== tb/tb_soc_top.sv ====
`default_nettype none

`include "soc_settings.svh"

module tb_soc_top;

    localparam int DEPTH = 2 ** `MEM_ADDR_WIDTH;
    localparam int NWR   = 16;

    typedef struct packed {
        logic              is_d;
        logic              wen;
        membus_pkg::addr_t addr;
        membus_pkg::word_t wdata;
        membus_pkg::word_t exp;
    } entry_t;

    logic              clk_in;
    logic              arst_n;
    logic              i_req_valid;
    logic              i_req_ready;
    membus_pkg::addr_t i_req_addr;
    logic              i_resp_valid;
    membus_pkg::word_t i_resp_rdata;
    logic              d_req_valid;
    logic              d_req_ready;
    membus_pkg::addr_t d_req_addr;
    logic              d_req_wen;
    membus_pkg::word_t d_req_wdata;
    logic              d_resp_valid;
    membus_pkg::word_t d_resp_rdata;
    logic              timer_irq;
    membus_pkg::word_t gp;
    logic              exited;

    entry_t            stim[$];
    membus_pkg::word_t shadow[DEPTH]; // Reference image of the memory
    int                errors = 0;
    int                i_resp_seen = 0;
    int                d_resp_seen = 0;
    int                i_resp_exp = 0;
    int                d_resp_exp = 0;
    longint            cyc = 0;
    longint            accept_cyc;
    bit                stim_built = 1'b0;

    soc_top dut (.*);

    initial clk_in = 1'b0;
    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) cyc <= cyc + 1;

    // Every response pulse seen on either port
    always @(negedge clk_in) begin
        if (arst_n && i_resp_valid) i_resp_seen++;
        if (arst_n && d_resp_valid) d_resp_seen++;
    end

    function automatic int fold(input membus_pkg::addr_t addr);
        return (addr >> 2) % DEPTH;
    endfunction

    function automatic membus_pkg::addr_t mmio_addr(input mmio_pkg::mmio_reg_e r);
        return `MMIO_BASE + {r, 2'b00};
    endfunction

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            errors++;
            $display("Fail %0t: %s", $time, what);
        end
    endtask

    task automatic check_word(input membus_pkg::word_t got, input membus_pkg::word_t exp,
                              input string what);
        assert (got === exp) else begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_entry(input logic is_d, input logic wen, input membus_pkg::addr_t addr,
                             input membus_pkg::word_t wdata);
        entry_t e;
        e.is_d  = is_d;
        e.wen   = wen;
        e.addr  = addr;
        e.wdata = wdata;
        if (wen) begin
            shadow[fold(addr)] = wdata;
        end
        e.exp = shadow[fold(addr)];
        stim.push_back(e);
    endtask

    // One request on one port and its single response one cycle after acceptance
    task automatic transact(input logic is_d, input logic wen, input membus_pkg::addr_t addr,
                            input membus_pkg::word_t wdata, output membus_pkg::word_t rdata);
        logic resp;
        @(negedge clk_in);
        if (is_d) begin
            d_req_valid = 1'b1;
            d_req_addr  = addr;
            d_req_wen   = wen;
            d_req_wdata = wdata;
        end else begin
            i_req_valid = 1'b1;
            i_req_addr  = addr;
        end
        #1;
        while (!(is_d ? d_req_ready : i_req_ready)) begin
            @(negedge clk_in);
            #1;
        end
        @(negedge clk_in); // Accepted at the posedge in between
        accept_cyc = cyc;
        resp  = is_d ? d_resp_valid : i_resp_valid;
        rdata = is_d ? d_resp_rdata : i_resp_rdata;
        check_true(resp, $sformatf("no response one cycle after accepting %h", addr));
        d_req_valid = 1'b0;
        i_req_valid = 1'b0;
        if (is_d) begin
            d_resp_exp++;
        end else begin
            i_resp_exp++;
        end
        @(negedge clk_in);
        check_true(!(is_d ? d_resp_valid : i_resp_valid), "response pulse longer than a cycle");
    endtask

    initial begin
        membus_pkg::word_t rd;
        membus_pkg::word_t t0;
        membus_pkg::word_t t1;
        membus_pkg::word_t cmp;
        membus_pkg::word_t gpv;
        membus_pkg::addr_t waddr[NWR];
        longint            c0;
        longint            k;
        int                n;

        void'($urandom(32'hb534a452));
        arst_n      = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        d_req_valid = 1'b0;
        d_req_addr  = '0;
        d_req_wen   = 1'b0;
        d_req_wdata = '0;
        foreach (shadow[a]) shadow[a] = '0;

        for (int j = 0; j < NWR; j++) begin
            waddr[j] = ($urandom % DEPTH) * 4;
            add_entry(1'b1, 1'b1, waddr[j], $urandom);
        end
        for (int j = 0; j < NWR; j++) begin
            add_entry(1'b1, 1'b0, waddr[j], '0);
            add_entry(1'b0, 1'b0, waddr[j], '0);
        end
        for (int j = 0; j < 4; j++) begin
            add_entry(j[0], 1'b0, waddr[j] + (j + 1) * DEPTH * 4, '0); // Aliased reads
        end
        add_entry(1'b1, 1'b1, waddr[5] + 3 * DEPTH * 4, $urandom); // Aliased write
        add_entry(1'b0, 1'b0, waddr[5], '0);
        stim_built = 1'b1;

        repeat (8) @(negedge clk_in);
        arst_n = 1'b1;
        check_true(!timer_irq && !exited, "timer_irq or exited high after reset");
        check_true(!i_resp_valid && !d_resp_valid, "response valid high after reset");
        check_word(gp, '0, "gp after reset");

        foreach (stim[j]) begin
            transact(stim[j].is_d, stim[j].wen, stim[j].addr, stim[j].wdata, rd);
            if (!stim[j].wen) begin
                check_word(rd, stim[j].exp, $sformatf("%s read of %h",
                           stim[j].is_d ? "data" : "fetch", stim[j].addr));
            end
        end

        // Same-cycle requests from both masters
        @(negedge clk_in);
        d_req_valid = 1'b1;
        d_req_addr  = waddr[1];
        d_req_wen   = 1'b0;
        i_req_valid = 1'b1;
        i_req_addr  = waddr[2];
        #1;
        check_true(d_req_ready && !i_req_ready, "data request did not win arbitration");
        @(negedge clk_in);
        check_true(d_resp_valid && !i_resp_valid, "data response missing after arbitration");
        check_word(d_resp_rdata, shadow[fold(waddr[1])], "arbitrated data read");
        check_true(!i_req_ready, "fetch accepted while data was served");
        d_req_valid = 1'b0;
        d_resp_exp++;
        #1;
        while (!i_req_ready) begin
            @(negedge clk_in);
            #1;
        end
        @(negedge clk_in);
        check_true(i_resp_valid && !d_resp_valid, "fetch response missing after data");
        check_word(i_resp_rdata, shadow[fold(waddr[2])], "arbitrated fetch read");
        i_req_valid = 1'b0;
        i_resp_exp++;
        @(negedge clk_in);

        transact(1'b1, 1'b0, mmio_addr(mmio_pkg::MTIME_HI), '0, rd);
        check_word(rd, '0, "MTIME_HI early in the run");
        transact(1'b1, 1'b0, mmio_addr(mmio_pkg::MTIME_LO), '0, t0);
        c0 = accept_cyc;
        repeat (200) @(negedge clk_in);
        transact(1'b1, 1'b0, mmio_addr(mmio_pkg::MTIME_LO), '0, t1);
        k = accept_cyc - c0;
        check_true((t1 - t0) == k / `FMAX_MHZ || (t1 - t0) == k / `FMAX_MHZ + 1,
                   $sformatf("mtime moved by %0d over %0d cycles", t1 - t0, k));

        // Compare point four microseconds ahead
        transact(1'b1, 1'b1, mmio_addr(mmio_pkg::MTIMECMP_HI), '0, rd);
        transact(1'b1, 1'b0, mmio_addr(mmio_pkg::MTIME_LO), '0, t0);
        cmp = t0 + 4;
        transact(1'b1, 1'b1, mmio_addr(mmio_pkg::MTIMECMP_LO), cmp, rd);
        check_true(!timer_irq, "timer_irq high before the compare time");
        n = 0;
        while (!timer_irq && n < 5 * `FMAX_MHZ) begin
            @(negedge clk_in);
            n++;
        end
        check_true(timer_irq, "timer_irq did not rise in time");
        transact(1'b1, 1'b0, mmio_addr(mmio_pkg::MTIME_LO), '0, t1);
        check_true(t1 >= cmp, $sformatf("mtime %h below compare %h", t1, cmp));

        gpv = $urandom & ~32'h1;
        transact(1'b1, 1'b1, mmio_addr(mmio_pkg::GP), gpv, rd);
        check_word(gp, gpv, "gp after write with bit 0 clear");
        check_true(!exited, "exited set by a gp write with bit 0 clear");
        transact(1'b1, 1'b1, mmio_addr(mmio_pkg::GP), gpv | 32'h1, rd);
        check_true(exited, "exited not set by a gp write with bit 0 set");
        gpv = $urandom & ~32'h1;
        transact(1'b1, 1'b1, mmio_addr(mmio_pkg::GP), gpv, rd);
        check_true(exited, "exited dropped after a later gp write");
        transact(1'b1, 1'b0, mmio_addr(mmio_pkg::GP), '0, rd);
        check_word(rd, gpv, "GP read back");

        repeat (2) @(negedge clk_in);
        check_true(i_resp_seen == i_resp_exp, "fetch responses lost or duplicated");
        check_true(d_resp_seen == d_resp_exp, "data responses lost or duplicated");
        $display("Errors: %0d, fetch responses %0d, data responses %0d",
                 errors, i_resp_seen, d_resp_seen);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (stim_built);
        limit = stim.size() * 8 + 20000;
        repeat (limit) @(posedge clk_in);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
